// ==== logic/branchPredict_params.svh ====
`ifndef BRANCH_PREDICT_PARAMS_SVH
`define BRANCH_PREDICT_PARAMS_SVH

// instruction address width
`define BP_WORD_WIDTH 32

`define BP_INDEX_BITS 4
`define BP_ENTRIES (1 << `BP_INDEX_BITS)

// what is left of the address above the index and the byte offset
`define BP_TAG_BITS (`BP_WORD_WIDTH - `BP_INDEX_BITS - 2)

`define BP_RESET_PC 32'h0000_1000

`define BP_APB_ADDR_WIDTH 8

`endif

// ==== logic/branchPredictPkg.sv ====
`include "branchPredict_params.svh"

package branchPredictPkg;

    typedef struct packed {
        logic [`BP_TAG_BITS-1:0]   tag;
        logic [`BP_INDEX_BITS-1:0] index;
        logic [1:0]                offset; // always zero for aligned fetch
    } pcFields_t;

    // one address word, read either whole or split into table fields
    typedef union packed {
        logic [`BP_WORD_WIDTH-1:0] raw;
        pcFields_t                 fields;
    } pcAddr_u;

    // upper bit set means the branch is predicted taken
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b10,
        strongTaken    = 2'b11
    } counter_e;

    localparam logic [`BP_APB_ADDR_WIDTH-1:0] CSR_CTRL        = 8'h00;
    localparam logic [`BP_APB_ADDR_WIDTH-1:0] CSR_BRANCH_CNT  = 8'h04;
    localparam logic [`BP_APB_ADDR_WIDTH-1:0] CSR_MISPRED_CNT = 8'h08;

endpackage

// ==== logic/predictIfs.sv ====
`include "branchPredict_params.svh"

// fetch side asks the table about the current fetch address
interface btbLookupIf;
    branchPredictPkg::pcAddr_u lookupPc;
    logic                      hit;
    logic                      counterTaken;
    logic [`BP_WORD_WIDTH-1:0] target;

    modport requester (
        output lookupPc,
        input  hit,
        input  counterTaken,
        input  target
    );

    modport btbTable (
        input  lookupPc,
        output hit,
        output counterTaken,
        output target
    );
endinterface

// a resolved instruction coming back from execute
interface resolveIf;
    logic                      valid;
    logic                      isBranch;
    logic                      taken;
    branchPredictPkg::pcAddr_u pc;
    logic [`BP_WORD_WIDTH-1:0] target;

    modport consumer (
        input valid,
        input isBranch,
        input taken,
        input pc,
        input target
    );
endinterface

// ==== logic/branchTargetBuffer.sv ====
`include "branchPredict_params.svh"

module branchTargetBuffer (
    input  logic        clk,
    input  logic        arstN,
    input  logic        flush,
    btbLookupIf.btbTable lookup,
    resolveIf.consumer  resolve
);

    logic [`BP_ENTRIES-1:0]    validBits;
    logic [`BP_TAG_BITS-1:0]   tagMem [`BP_ENTRIES];
    logic [`BP_WORD_WIDTH-1:0] targetMem [`BP_ENTRIES];
    branchPredictPkg::counter_e counterMem [`BP_ENTRIES];

    logic [`BP_INDEX_BITS-1:0] lookupIdx;
    logic [`BP_INDEX_BITS-1:0] resolveIdx;
    logic                      resolveHit;
    logic                      branchDone;
    logic                      train;
    logic                      allocate;

    // one saturating step toward the resolved outcome
    function automatic branchPredictPkg::counter_e stepCounter(
        input branchPredictPkg::counter_e cur,
        input logic                       taken
    );
        branchPredictPkg::counter_e nxt;
        nxt = cur;
        case (cur)
            branchPredictPkg::strongNotTaken:
                nxt = taken ? branchPredictPkg::weakNotTaken : branchPredictPkg::strongNotTaken;
            branchPredictPkg::weakNotTaken:
                nxt = taken ? branchPredictPkg::weakTaken : branchPredictPkg::strongNotTaken;
            branchPredictPkg::weakTaken:
                nxt = taken ? branchPredictPkg::strongTaken : branchPredictPkg::weakNotTaken;
            branchPredictPkg::strongTaken:
                nxt = taken ? branchPredictPkg::strongTaken : branchPredictPkg::weakTaken;
            default:
                nxt = branchPredictPkg::weakTaken;
        endcase
        return nxt;
    endfunction

    // lookup is purely combinational on the current table
    assign lookupIdx = lookup.lookupPc.fields.index;

    assign lookup.hit = validBits[lookupIdx]
                        && (tagMem[lookupIdx] == lookup.lookupPc.fields.tag);
    assign lookup.counterTaken = counterMem[lookupIdx][1];
    assign lookup.target       = targetMem[lookupIdx];

    assign resolveIdx = resolve.pc.fields.index;
    assign resolveHit = validBits[resolveIdx]
                        && (tagMem[resolveIdx] == resolve.pc.fields.tag);
    assign branchDone = resolve.valid && resolve.isBranch;

    // a not-taken miss leaves the table alone
    assign train    = branchDone && resolveHit && !flush;
    assign allocate = branchDone && !resolveHit && resolve.taken && !flush;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validBits <= '0;
        end else if (flush) begin
            validBits <= '0; // flush beats any update on the same edge
        end else if (allocate) begin
            validBits[resolveIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (allocate) begin
            tagMem[resolveIdx]     <= resolve.pc.fields.tag;
            targetMem[resolveIdx]  <= resolve.target;
            counterMem[resolveIdx] <= branchPredictPkg::weakTaken;
        end else if (train) begin
            counterMem[resolveIdx] <= stepCounter(counterMem[resolveIdx], resolve.taken);
        end
    end

    // a valid entry always carries a written target and counter
    hitFieldsKnownA: assert property (
        @(posedge clk) disable iff (!arstN)
        lookup.hit |-> !$isunknown({lookup.counterTaken, lookup.target})
    ) else $error("btb hit on an entry with unwritten fields");

endmodule

// ==== logic/nextPcSelect.sv ====
`include "branchPredict_params.svh"

module nextPcSelect (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      predictEnable,
    input  logic                      fetchStall,
    btbLookupIf.requester             lookup,
    resolveIf.consumer                resolve,
    input  logic                      resolvePredTaken,
    input  logic [`BP_WORD_WIDTH-1:0] resolvePredTarget,
    output logic [`BP_WORD_WIDTH-1:0] fetchPc,
    output logic [`BP_WORD_WIDTH-1:0] fetchPredTarget,
    output logic                      fetchPredTaken,
    output logic                      redirect,
    output logic                      mispredict
);

    logic [`BP_WORD_WIDTH-1:0] correctPc;
    logic [`BP_WORD_WIDTH-1:0] nextPc;
    logic                      wrongDir;
    logic                      wrongTarget;
    logic                      falseTaken;

    assign lookup.lookupPc = branchPredictPkg::pcAddr_u'(fetchPc);

    assign fetchPredTaken  = lookup.hit && lookup.counterTaken && predictEnable;
    assign fetchPredTarget = lookup.target;

    assign wrongDir    = resolve.isBranch && (resolve.taken != resolvePredTaken);
    assign wrongTarget = resolve.isBranch && resolve.taken
                         && (resolve.target != resolvePredTarget);
    assign falseTaken  = !resolve.isBranch && resolvePredTaken; // e.g. stale entry on a non-branch

    assign mispredict = resolve.valid && (wrongDir || wrongTarget || falseTaken);
    assign redirect   = mispredict;

    assign correctPc = resolve.taken ? resolve.target
                                     : resolve.pc.raw + `BP_WORD_WIDTH'(4);

    // redirect overrides the stall, the stall overrides the prediction
    always_comb begin
        if (redirect) begin
            nextPc = correctPc;
        end else if (fetchStall) begin
            nextPc = fetchPc;
        end else if (fetchPredTaken) begin
            nextPc = fetchPredTarget;
        end else begin
            nextPc = fetchPc + `BP_WORD_WIDTH'(4);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchPc <= `BP_RESET_PC;
        end else begin
            fetchPc <= nextPc;
        end
    end

    // targets come from both the table and execute, so check the register itself
    fetchPcAlignedA: assert property (
        @(posedge clk) disable iff (!arstN)
        fetchPc[1:0] == 2'b00
    ) else $error("fetchPc lost word alignment");

endmodule

// ==== logic/predictorCsr.sv ====
`include "branchPredict_params.svh"

module predictorCsr (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [`BP_APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`BP_WORD_WIDTH-1:0]    pwdata,
    output logic [`BP_WORD_WIDTH-1:0]    prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  logic                         branchResolved,
    input  logic                         mispredict,
    output logic                         predictEnable,
    output logic                         flush
);

    logic                      access;
    logic                      writeEn;
    logic                      selCtrl;
    logic                      selBranch;
    logic                      selMispred;
    logic [`BP_WORD_WIDTH-1:0] branchCnt;
    logic [`BP_WORD_WIDTH-1:0] mispredCnt;

    assign access  = psel && penable;
    assign writeEn = access && pwrite;

    assign selCtrl    = (paddr == branchPredictPkg::CSR_CTRL);
    assign selBranch  = (paddr == branchPredictPkg::CSR_BRANCH_CNT);
    assign selMispred = (paddr == branchPredictPkg::CSR_MISPRED_CNT);

    assign pready  = 1'b1; // no wait states
    assign pslverr = access && !(selCtrl || selBranch || selMispred);

    // flush bit always reads back as zero
    always_comb begin
        prdata = '0;
        if (selCtrl) begin
            prdata[0] = predictEnable;
        end else if (selBranch) begin
            prdata = branchCnt;
        end else if (selMispred) begin
            prdata = mispredCnt;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            predictEnable <= 1'b0;
            flush         <= 1'b0;
        end else begin
            flush <= writeEn && selCtrl && pwdata[1]; // single cycle pulse
            if (writeEn && selCtrl) begin
                predictEnable <= pwdata[0];
            end
        end
    end

    // a write clears the counter and beats an increment on the same edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            branchCnt  <= '0;
            mispredCnt <= '0;
        end else begin
            if (writeEn && selBranch) begin
                branchCnt <= '0;
            end else if (branchResolved) begin
                branchCnt <= branchCnt + 1'b1;
            end

            if (writeEn && selMispred) begin
                mispredCnt <= '0;
            end else if (mispredict) begin
                mispredCnt <= mispredCnt + 1'b1;
            end
        end
    end

    apbEnableNeedsSelA: assert property (
        @(posedge clk) disable iff (!arstN)
        $rose(penable) |-> psel
    ) else $error("penable rose without psel");

endmodule

// ==== logic/fetchPredictTop.sv ====
`include "branchPredict_params.svh"

module fetchPredictTop (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          fetchStall,
    output logic [`BP_WORD_WIDTH-1:0]     fetchPc,
    output logic                          fetchPredTaken,
    output logic [`BP_WORD_WIDTH-1:0]     fetchPredTarget,
    input  logic                          resolveValid,
    input  logic                          resolveIsBranch,
    input  logic                          resolveTaken,
    input  logic [`BP_WORD_WIDTH-1:0]     resolvePc,
    input  logic [`BP_WORD_WIDTH-1:0]     resolveTarget,
    input  logic                          resolvePredTaken,
    input  logic [`BP_WORD_WIDTH-1:0]     resolvePredTarget,
    output logic                          redirect,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`BP_APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`BP_WORD_WIDTH-1:0]     pwdata,
    output logic [`BP_WORD_WIDTH-1:0]     prdata,
    output logic                          pready,
    output logic                          pslverr
);

    logic predictEnable;
    logic flush;
    logic mispredict;
    logic branchResolved;

    btbLookupIf lookupBus ();
    resolveIf   resolveBus ();

    assign resolveBus.valid    = resolveValid;
    assign resolveBus.isBranch = resolveIsBranch;
    assign resolveBus.taken    = resolveTaken;
    assign resolveBus.pc       = branchPredictPkg::pcAddr_u'(resolvePc);
    assign resolveBus.target   = resolveTarget;

    // only real branches count toward the statistics
    assign branchResolved = resolveValid && resolveIsBranch;

    branchTargetBuffer btb (
        .clk     (clk),
        .arstN   (arstN),
        .flush   (flush),
        .lookup  (lookupBus.btbTable),
        .resolve (resolveBus.consumer)
    );

    nextPcSelect pcSel (
        .clk               (clk),
        .arstN             (arstN),
        .predictEnable     (predictEnable),
        .fetchStall        (fetchStall),
        .lookup            (lookupBus.requester),
        .resolve           (resolveBus.consumer),
        .resolvePredTaken  (resolvePredTaken),
        .resolvePredTarget (resolvePredTarget),
        .fetchPc           (fetchPc),
        .fetchPredTarget   (fetchPredTarget),
        .fetchPredTaken    (fetchPredTaken),
        .redirect          (redirect),
        .mispredict        (mispredict)
    );

    predictorCsr csr (
        .clk            (clk),
        .arstN          (arstN),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .branchResolved (branchResolved),
        .mispredict     (mispredict),
        .predictEnable  (predictEnable),
        .flush          (flush)
    );

endmodule

// ==== verif/fetchPredictTb.sv ====
`include "branchPredict_params.svh"

module fetchPredictTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TAG_LO = `BP_INDEX_BITS + 2;
    localparam int RAND_OPS = 240;
    localparam int DISABLED_OPS = 40;
    localparam int NUM_OPS = RAND_OPS + DISABLED_OPS + 30;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 4 + 100;

    logic clk;
    logic arstN;
    logic fetchStall;
    logic [31:0] fetchPc, fetchPredTarget;
    logic fetchPredTaken, redirect;
    logic resolveValid, resolveIsBranch, resolveTaken, resolvePredTaken;
    logic [31:0] resolvePc, resolveTarget, resolvePredTarget;
    logic psel, penable, pwrite, pready, pslverr;
    logic [7:0] paddr;
    logic [31:0] pwdata, prdata;

    // reference model state
    logic [31:0] expPc, expNextPc, expPredTarget, expRdata, mBranchCnt, mMispredCnt;
    logic expPredTaken, expRedirect, expSlvErr, mEnable, mFlush, rHit, apbWr;
    logic mValid [`BP_ENTRIES];
    logic [`BP_TAG_BITS-1:0] mTag [`BP_ENTRIES];
    logic [31:0] mTarget [`BP_ENTRIES];
    logic [1:0] mCnt [`BP_ENTRIES]; // 2'b11 is strongly taken
    logic [`BP_INDEX_BITS-1:0] rIdx;
    logic [31:0] rngState;

    // 0x1008 and 0x2008 share an index but not a tag
    logic [31:0] branchPcs [6] = '{32'h1008, 32'h1014, 32'h1020, 32'h1030, 32'h103c, 32'h2008};
    logic [31:0] branchTargets [6] = '{32'h1000, 32'h1004, 32'h1010, 32'h1000, 32'h1018,
                                       32'h2000};

    fetchPredictTop uut (.*);

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic predictFor(input logic [31:0] pc);
        logic [`BP_INDEX_BITS-1:0] idx;
        idx = pc[TAG_LO-1:2];
        return mEnable && mValid[idx] && (mTag[idx] == pc[31:TAG_LO]) && mCnt[idx][1];
    endfunction

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic apbAccess(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel <= 1'b1;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic resolveBranch(input logic [31:0] pc, input logic isBr, input logic taken,
                                 input logic [31:0] target, input logic predT,
                                 input logic [31:0] predTgt, input logic stall);
        @(posedge clk);
        fetchStall <= stall;
        resolveValid <= 1'b1;
        resolveIsBranch <= isBr;
        resolveTaken <= taken;
        resolvePc <= pc;
        resolveTarget <= target;
        resolvePredTaken <= predT;
        resolvePredTarget <= predTgt;
        @(posedge clk);
        resolveValid <= 1'b0;
    endtask

    // carries the model's prediction for the chosen PC, sometimes spoiled on purpose
    task automatic randomResolve();
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] target;
        logic predT;
        int sel;
        rngState = nextRandom(rngState);
        r = rngState;
        sel = r[2:0] % 6;
        pc = branchPcs[sel];
        target = (r[19:17] == 3'd0) ? 32'h1000 + {r[27:22], 2'b00} : branchTargets[sel];
        predT = predictFor(pc) ^ (r[5:3] == 3'd0);
        resolveBranch(pc, r[15:11] != 5'd0, r[16] && (r[15:11] != 5'd0), target, predT,
                      mTarget[pc[TAG_LO-1:2]] ^ ((r[8:6] == 3'd0) ? 32'h40 : 32'h0),
                      r[9] && r[10]);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign rIdx = resolvePc[TAG_LO-1:2];
    assign apbWr = psel && penable && pwrite;

    always_comb begin
        rHit = mValid[rIdx] && (mTag[rIdx] == resolvePc[31:TAG_LO]);
        expPredTaken = predictFor(expPc);
        expPredTarget = mTarget[expPc[TAG_LO-1:2]];
        expRedirect = resolveValid && (resolveIsBranch
            ? (resolveTaken != resolvePredTaken) || (resolveTaken && resolveTarget != resolvePredTarget)
            : resolvePredTaken);
        if (expRedirect) begin
            expNextPc = resolveTaken ? resolveTarget : resolvePc + 32'd4;
        end else if (fetchStall) begin
            expNextPc = expPc;
        end else if (expPredTaken) begin
            expNextPc = expPredTarget;
        end else begin
            expNextPc = expPc + 32'd4;
        end
        expSlvErr = 1'b0;
        case (paddr)
            branchPredictPkg::CSR_CTRL: expRdata = {31'd0, mEnable};
            branchPredictPkg::CSR_BRANCH_CNT: expRdata = mBranchCnt;
            branchPredictPkg::CSR_MISPRED_CNT: expRdata = mMispredCnt;
            default: begin
                expRdata = 32'd0;
                expSlvErr = 1'b1;
            end
        endcase
    end

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expPc <= `BP_RESET_PC;
            mEnable <= 1'b0;
            mFlush <= 1'b0;
            mBranchCnt <= '0;
            mMispredCnt <= '0;
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                mValid[i] <= 1'b0;
                mTag[i] <= '0;
                mTarget[i] <= '0;
                mCnt[i] <= 2'b00;
            end
        end else begin
            expPc <= expNextPc;
            mFlush <= apbWr && (paddr == branchPredictPkg::CSR_CTRL) && pwdata[1];
            if (apbWr && (paddr == branchPredictPkg::CSR_CTRL)) mEnable <= pwdata[0];
            if (mFlush) begin
                for (int i = 0; i < `BP_ENTRIES; i++) mValid[i] <= 1'b0;
            end else if (resolveValid && resolveIsBranch && rHit) begin
                if (resolveTaken && mCnt[rIdx] != 2'b11) mCnt[rIdx] <= mCnt[rIdx] + 2'd1;
                else if (!resolveTaken && mCnt[rIdx] != 2'b00) mCnt[rIdx] <= mCnt[rIdx] - 2'd1;
            end else if (resolveValid && resolveIsBranch && resolveTaken) begin
                mValid[rIdx] <= 1'b1; // new entries start weakly taken
                mTag[rIdx] <= resolvePc[31:TAG_LO];
                mTarget[rIdx] <= resolveTarget;
                mCnt[rIdx] <= 2'b10;
            end
            if (apbWr && (paddr == branchPredictPkg::CSR_BRANCH_CNT)) mBranchCnt <= '0;
            else if (resolveValid && resolveIsBranch) mBranchCnt <= mBranchCnt + 32'd1;
            if (apbWr && (paddr == branchPredictPkg::CSR_MISPRED_CNT)) mMispredCnt <= '0;
            else if (expRedirect) mMispredCnt <= mMispredCnt + 32'd1;
        end
    end

    resetPcA: assert property (@(posedge clk) $rose(arstN) |-> fetchPc == `BP_RESET_PC)
        else stopWithFailure($sformatf("[FAIL] fetchPc after reset: got %h, expected %h",
                                       $sampled(fetchPc), `BP_RESET_PC));
    pcMatchA: assert property (@(posedge clk) disable iff (!arstN) fetchPc == expPc)
        else stopWithFailure($sformatf("[FAIL] fetchPc: got %h, expected %h",
                                       $sampled(fetchPc), $sampled(expPc)));
    predMatchA: assert property (@(posedge clk) disable iff (!arstN)
                                 fetchPredTaken == expPredTaken)
        else stopWithFailure($sformatf("[FAIL] fetchPredTaken: got %h, expected %h",
                                       $sampled(fetchPredTaken), $sampled(expPredTaken)));
    targetMatchA: assert property (@(posedge clk) disable iff (!arstN)
                                   fetchPredTaken |-> fetchPredTarget == expPredTarget)
        else stopWithFailure($sformatf("[FAIL] fetchPredTarget: got %h, expected %h",
                                       $sampled(fetchPredTarget), $sampled(expPredTarget)));
    redirectMatchA: assert property (@(posedge clk) disable iff (!arstN) redirect == expRedirect)
        else stopWithFailure($sformatf("[FAIL] redirect: got %h, expected %h",
                                       $sampled(redirect), $sampled(expRedirect)));
    readDataA: assert property (@(posedge clk) disable iff (!arstN)
                                psel && penable && !pwrite |-> prdata == expRdata)
        else stopWithFailure($sformatf("[FAIL] prdata: got %h, expected %h",
                                       $sampled(prdata), $sampled(expRdata)));
    slvErrA: assert property (@(posedge clk) disable iff (!arstN)
                              psel && penable |-> pslverr == expSlvErr)
        else stopWithFailure($sformatf("[FAIL] pslverr: got %h, expected %h",
                                       $sampled(pslverr), $sampled(expSlvErr)));
    readyA: assert property (@(posedge clk) disable iff (!arstN) psel && penable |-> pready)
        else stopWithFailure($sformatf("[FAIL] pready: got %h, expected %h",
                                       $sampled(pready), 1'b1));

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        stopWithFailure("the run timed out before all operations completed");
    end

    initial begin
        rngState = 32'h3b53;
        arstN <= 1'b0;
        {fetchStall, resolveValid, resolveIsBranch, resolveTaken, resolvePredTaken} <= '0;
        {resolvePc, resolveTarget, resolvePredTarget} <= '0;
        {psel, penable, pwrite, paddr, pwdata} <= '0;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        repeat (3) @(posedge clk);
        fetchStall <= 1'b1; // hold a few cycles before predictions exist
        repeat (3) @(posedge clk);
        fetchStall <= 1'b0;

        apbAccess(1'b1, branchPredictPkg::CSR_CTRL, 32'h1);
        resolveBranch(32'h1008, 1'b1, 1'b1, 32'h1000, 1'b0, 32'h0, 1'b0);
        repeat (8) @(posedge clk);
        // walk the counter down to strongly not taken and back up again
        resolveBranch(32'h1008, 1'b1, 1'b0, 32'h1000, 1'b1, 32'h1000, 1'b0);
        resolveBranch(32'h1008, 1'b1, 1'b0, 32'h1000, 1'b0, 32'h1000, 1'b1);
        resolveBranch(32'h1008, 1'b1, 1'b1, 32'h1000, 1'b0, 32'h1000, 1'b0);
        resolveBranch(32'h1008, 1'b1, 1'b1, 32'h1000, 1'b0, 32'h1000, 1'b0);
        repeat (8) @(posedge clk);

        for (int i = 0; i < RAND_OPS; i++) randomResolve();

        apbAccess(1'b0, branchPredictPkg::CSR_BRANCH_CNT, 32'h0);
        apbAccess(1'b0, branchPredictPkg::CSR_MISPRED_CNT, 32'h0);
        apbAccess(1'b1, branchPredictPkg::CSR_BRANCH_CNT, 32'h0);
        apbAccess(1'b1, branchPredictPkg::CSR_MISPRED_CNT, 32'h0);
        apbAccess(1'b0, branchPredictPkg::CSR_BRANCH_CNT, 32'h0);
        apbAccess(1'b0, branchPredictPkg::CSR_MISPRED_CNT, 32'h0);
        apbAccess(1'b0, 8'h0C, 32'h0);
        apbAccess(1'b1, 8'h0C, 32'hffff_ffff);
        // make 0x1008 predict taken, flush, then redirect fetch straight onto it
        resolveBranch(32'h1008, 1'b1, 1'b1, 32'h1000, 1'b0, 32'h1000, 1'b0);
        resolveBranch(32'h1008, 1'b1, 1'b1, 32'h1000, 1'b0, 32'h1000, 1'b0);
        apbAccess(1'b1, branchPredictPkg::CSR_CTRL, 32'h3);
        resolveBranch(32'h1004, 1'b0, 1'b0, 32'h0, 1'b1, 32'h0, 1'b0);
        apbAccess(1'b0, branchPredictPkg::CSR_CTRL, 32'h0);
        repeat (6) @(posedge clk);
        apbAccess(1'b1, branchPredictPkg::CSR_CTRL, 32'h0);

        for (int i = 0; i < DISABLED_OPS; i++) randomResolve();
        apbAccess(1'b0, branchPredictPkg::CSR_BRANCH_CNT, 32'h0);
        apbAccess(1'b0, branchPredictPkg::CSR_MISPRED_CNT, 32'h0);
        repeat (4) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+logic
logic/branchPredictPkg.sv
logic/predictIfs.sv
logic/branchTargetBuffer.sv
logic/nextPcSelect.sv
logic/predictorCsr.sv
logic/fetchPredictTop.sv
verif/fetchPredictTb.sv

// ==== Bender.yml ====
package:
  name: fetch_predict

sources:
  - include_dirs:
      - logic
    files:
      - logic/branchPredictPkg.sv
      - logic/predictIfs.sv
      - logic/branchTargetBuffer.sv
      - logic/nextPcSelect.sv
      - logic/predictorCsr.sv
      - logic/fetchPredictTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/fetchPredictTb.sv
